// ==== include/xm_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host register block constants
//  - word, byte and register number widths
//  - number of implemented registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef XM_CONSTS_SVH
`define XM_CONSTS_SVH

// register and video memory word
`define XM_WORD_W       16

// host bus byte lane
`define XM_BYTE_W       8

`define XM_REG_NUM_W    4               // register space is 16 entries
`define XM_REG_COUNT    8               // numbers 8..15 read as zero

`endif

// ==== src/xm_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the host register block
//  - word, address and byte vectors
//  - register numbers and FSM states
//  - bus, command, memory and readback structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "xm_consts.svh"

package xm_pkg;

    typedef logic [`XM_WORD_W-1:0] word_t;      // register / memory word
    typedef logic [`XM_WORD_W-1:0] addr_t;      // video memory or XR address
    typedef logic [`XM_BYTE_W-1:0] byte_t;      // host bus byte

    // register numbers, codes 8..15 left unnamed
    typedef enum logic [`XM_REG_NUM_W-1:0] {
        XM_XR_ADDR = 4'h0,
        XM_XR_DATA = 4'h1,
        XM_RD_INCR = 4'h2,
        XM_RD_ADDR = 4'h3,
        XM_WR_INCR = 4'h4,
        XM_WR_ADDR = 4'h5,
        XM_DATA    = 4'h6,
        XM_DATA_2  = 4'h7
    } xm_reg_e;

    typedef enum logic [1:0] {
        EXEC_IDLE,                              // ready for a command
        EXEC_REQ,                               // building memory request
        EXEC_WAIT                               // request out, waiting for response
    } exec_state_e;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_WRITE,                              // full word written to a register
        CMD_PREFETCH                            // odd byte of DATA was read
    } cmd_kind_e;

    typedef struct packed {
        logic                     rd_nwr;       // 1 = read
        logic [`XM_REG_NUM_W-1:0] reg_num;
        logic                     bytesel;      // 1 = odd (low) byte
        byte_t                    data;
    } bus_txn_t;

    typedef struct packed {
        cmd_kind_e                kind;
        logic [`XM_REG_NUM_W-1:0] reg_num;
        word_t                    word;
    } xm_cmd_t;

    typedef struct packed {
        logic  xr_sel;                          // 1 = XR bus, 0 = video memory
        logic  wr;
        addr_t addr;
        word_t data;
    } mem_req_t;

    typedef struct packed {
        word_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic  xr_sel;
        word_t data;
    } xm_done_t;

    typedef struct packed {
        addr_t xr_addr;
        word_t rd_incr;
        addr_t rd_addr;
        word_t wr_incr;
        addr_t wr_addr;
    } xm_regs_t;

endpackage

`default_nettype wire

// ==== src/xm_bus_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host bus byte decoder
//  - pairs even and odd byte writes into words
//  - prefetch command on odd DATA read
//  - forwards reads, drives bus back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "xm_consts.svh"

module xm_bus_decode
    import xm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     bus_valid_i,
    input  wire bus_txn_t bus_txn_i,
    output      logic     bus_ready_o,
    input  wire logic     exec_busy_i,
    output      xm_cmd_t  cmd_o,
    output      logic     cmd_valid_o,
    input  wire logic     cmd_ready_i,
    output      bus_txn_t rd_txn_o,
    output      logic     rd_valid_o
);

byte_t   even_q;                                // even byte awaiting its odd partner
logic    accept;
logic    reg_used;                              // register number below 8
xm_cmd_t cmd_next;

assign bus_ready_o = !cmd_valid_o && !exec_busy_i;
assign accept      = bus_valid_i && bus_ready_o;
assign reg_used    = (bus_txn_i.reg_num < `XM_REG_COUNT);

always_comb begin
    cmd_next.kind    = CMD_NONE;
    cmd_next.reg_num = bus_txn_i.reg_num;
    cmd_next.word    = {even_q, bus_txn_i.data};    // even byte is the high byte
    if (bus_txn_i.bytesel && reg_used) begin
        if (!bus_txn_i.rd_nwr) begin
            cmd_next.kind = CMD_WRITE;
        end else if (bus_txn_i.reg_num == XM_DATA || bus_txn_i.reg_num == XM_DATA_2) begin
            cmd_next.kind = CMD_PREFETCH;           // fetch next word behind the read
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        cmd_valid_o <= 1'b0;
        rd_valid_o  <= 1'b0;
        even_q      <= '0;
    end else begin
        rd_valid_o <= accept && bus_txn_i.rd_nwr;
        if (accept && cmd_next.kind != CMD_NONE) begin
            cmd_valid_o <= 1'b1;
        end else if (cmd_ready_i) begin
            cmd_valid_o <= 1'b0;                    // taken by execute
        end
        if (accept && !bus_txn_i.rd_nwr && !bus_txn_i.bytesel && reg_used) begin
            even_q <= bus_txn_i.data;
        end
    end
end

// ready is low while a command is pending, so these stay stable
always_ff @(posedge clk) begin
    if (accept) begin
        cmd_o    <= cmd_next;
        rd_txn_o <= bus_txn_i;
    end
end

endmodule

`default_nettype wire

// ==== src/xm_reg_execute.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register execute stage
//  - XR_ADDR, RD_INCR, RD_ADDR, WR_INCR, WR_ADDR
//  - one memory request in flight at a time
//  - address increments on completion
//  - read data handed to the result stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "xm_consts.svh"

module xm_reg_execute
    import xm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire xm_cmd_t  cmd_i,
    input  wire logic     cmd_valid_i,
    output      logic     cmd_ready_o,
    output      logic     busy_o,
    output      mem_req_t mem_req_o,
    output      logic     mem_req_valid_o,
    input  wire logic     mem_req_ready_i,
    input  wire mem_rsp_t mem_rsp_i,
    input  wire logic     mem_rsp_valid_i,
    output      xm_done_t done_o,
    output      logic     done_valid_o,
    output      xm_regs_t regs_o
);

exec_state_e state_q;
xm_cmd_t     pend_q;                            // command being executed
addr_t       xr_addr_q;
word_t       rd_incr_q;
addr_t       rd_addr_q;
word_t       wr_incr_q;
addr_t       wr_addr_q;
logic        cmd_take;
logic        cmd_mem;                           // command needs a memory access
mem_req_t    req_next;

assign cmd_ready_o = (state_q == EXEC_IDLE);
assign busy_o      = (state_q != EXEC_IDLE);
assign cmd_take    = cmd_valid_i && cmd_ready_o;

assign regs_o.xr_addr = xr_addr_q;
assign regs_o.rd_incr = rd_incr_q;
assign regs_o.rd_addr = rd_addr_q;
assign regs_o.wr_incr = wr_incr_q;
assign regs_o.wr_addr = wr_addr_q;

always_comb begin
    cmd_mem = (cmd_i.kind == CMD_PREFETCH) ||
              (cmd_i.kind == CMD_WRITE &&
               cmd_i.reg_num inside {XM_XR_ADDR, XM_XR_DATA, XM_RD_ADDR, XM_DATA, XM_DATA_2});
end

// request built from the registers as updated by the command
always_comb begin
    req_next.xr_sel = 1'b0;
    req_next.wr     = 1'b0;
    req_next.addr   = rd_addr_q;                // RD_ADDR write and prefetch read here
    req_next.data   = pend_q.word;
    if (pend_q.kind == CMD_WRITE) begin
        case (pend_q.reg_num)
            XM_XR_ADDR: begin
                req_next.xr_sel = 1'b1;         // XR read into XR_DATA
                req_next.addr   = xr_addr_q;
            end
            XM_XR_DATA: begin
                req_next.xr_sel = 1'b1;
                req_next.wr     = 1'b1;
                req_next.addr   = xr_addr_q;
            end
            XM_DATA, XM_DATA_2: begin
                req_next.wr     = 1'b1;
                req_next.addr   = wr_addr_q;
            end
            default: begin
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state_q         <= EXEC_IDLE;
        mem_req_valid_o <= 1'b0;
        done_valid_o    <= 1'b0;
        xr_addr_q       <= '0;
        rd_incr_q       <= '0;
        rd_addr_q       <= '0;
        wr_incr_q       <= '0;
        wr_addr_q       <= '0;
    end else begin
        done_valid_o <= 1'b0;
        case (state_q)
            EXEC_IDLE: begin
                if (cmd_take) begin
                    if (cmd_i.kind == CMD_WRITE) begin
                        case (cmd_i.reg_num)
                            XM_XR_ADDR: xr_addr_q <= cmd_i.word;
                            XM_RD_INCR: rd_incr_q <= cmd_i.word;
                            XM_RD_ADDR: rd_addr_q <= cmd_i.word;
                            XM_WR_INCR: wr_incr_q <= cmd_i.word;
                            XM_WR_ADDR: wr_addr_q <= cmd_i.word;
                            default: begin
                            end
                        endcase
                    end
                    if (cmd_mem) begin
                        state_q <= EXEC_REQ;
                    end
                end
            end
            EXEC_REQ: begin
                mem_req_valid_o <= 1'b1;
                state_q         <= EXEC_WAIT;
            end
            EXEC_WAIT: begin
                if (mem_req_ready_i) begin
                    mem_req_valid_o <= 1'b0;    // accepted by memory
                end
                if (mem_rsp_valid_i) begin
                    mem_req_valid_o <= 1'b0;
                    done_valid_o    <= !mem_req_o.wr;
                    state_q         <= EXEC_IDLE;
                    if (mem_req_o.wr) begin
                        if (mem_req_o.xr_sel) begin
                            xr_addr_q <= xr_addr_q + 1'b1;
                        end else begin
                            wr_addr_q <= wr_addr_q + wr_incr_q;
                        end
                    end else if (!mem_req_o.xr_sel) begin
                        rd_addr_q <= rd_addr_q + rd_incr_q;     // XR reads do not step
                    end
                end
            end
            default: state_q <= EXEC_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (cmd_take) begin
        pend_q <= cmd_i;
    end
    if (state_q == EXEC_REQ) begin
        mem_req_o <= req_next;                  // held until the response
    end
    if (state_q == EXEC_WAIT && mem_rsp_valid_i) begin
        done_o.xr_sel <= mem_req_o.xr_sel;
        done_o.data   <= mem_rsp_i.data;
    end
end

endmodule

`default_nettype wire

// ==== src/xm_read_result.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read result stage
//  - DATA and XR_DATA read words
//  - register and byte select for bus reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "xm_consts.svh"

module xm_read_result
    import xm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire bus_txn_t rd_txn_i,
    input  wire logic     rd_valid_i,
    input  wire xm_done_t done_i,
    input  wire logic     done_valid_i,
    input  wire xm_regs_t regs_i,
    output      byte_t    bus_rdata_o,
    output      logic     bus_rvalid_o
);

word_t data_q;                                  // last video memory read
word_t xr_data_q;                               // last XR bus read
word_t sel_word;

always_ff @(posedge clk) begin
    if (reset_i) begin
        data_q    <= '0;
        xr_data_q <= '0;
    end else if (done_valid_i) begin
        if (done_i.xr_sel) begin
            xr_data_q <= done_i.data;
        end else begin
            data_q <= done_i.data;
        end
    end
end

always_comb begin
    case (rd_txn_i.reg_num)
        XM_XR_ADDR:         sel_word = regs_i.xr_addr;
        XM_XR_DATA:         sel_word = xr_data_q;
        XM_RD_INCR:         sel_word = regs_i.rd_incr;
        XM_RD_ADDR:         sel_word = regs_i.rd_addr;
        XM_WR_INCR:         sel_word = regs_i.wr_incr;
        XM_WR_ADDR:         sel_word = regs_i.wr_addr;
        XM_DATA, XM_DATA_2: sel_word = data_q;
        default:            sel_word = '0;      // unused numbers 8..15
    endcase
end

// even byte carries the high half
assign bus_rdata_o  = rd_txn_i.bytesel ? sel_word[`XM_BYTE_W-1:0]
                                       : sel_word[`XM_WORD_W-1 -: `XM_BYTE_W];
assign bus_rvalid_o = rd_valid_i;               // decode marks reads only

endmodule

`default_nettype wire

// ==== src/xm_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host register block top level
//  - bus decode, register execute, read result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "xm_consts.svh"

module xm_top
    import xm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     bus_valid_i,
    input  wire bus_txn_t bus_txn_i,
    output      logic     bus_ready_o,
    output      byte_t    bus_rdata_o,
    output      logic     bus_rvalid_o,
    output      mem_req_t mem_req_o,
    output      logic     mem_req_valid_o,
    input  wire logic     mem_req_ready_i,
    input  wire mem_rsp_t mem_rsp_i,
    input  wire logic     mem_rsp_valid_i
);

xm_cmd_t  cmd;
logic     cmd_valid;
logic     cmd_ready;
logic     exec_busy;                            // execute not idle
bus_txn_t rd_txn;
logic     rd_valid;
xm_done_t done;
logic     done_valid;
xm_regs_t regs;

xm_bus_decode u_decode (
    .clk         (clk),
    .reset_i     (reset_i),
    .bus_valid_i (bus_valid_i),
    .bus_txn_i   (bus_txn_i),
    .bus_ready_o (bus_ready_o),
    .exec_busy_i (exec_busy),
    .cmd_o       (cmd),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .rd_txn_o    (rd_txn),
    .rd_valid_o  (rd_valid)
);

xm_reg_execute u_execute (
    .clk             (clk),
    .reset_i         (reset_i),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid),
    .cmd_ready_o     (cmd_ready),
    .busy_o          (exec_busy),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .done_o          (done),
    .done_valid_o    (done_valid),
    .regs_o          (regs)
);

xm_read_result u_result (
    .clk          (clk),
    .reset_i      (reset_i),
    .rd_txn_i     (rd_txn),
    .rd_valid_i   (rd_valid),
    .done_i       (done),
    .done_valid_i (done_valid),
    .regs_i       (regs),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o)
);

endmodule

`default_nettype wire

// ==== sim/xm_tb_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake properties of the host register block
//  - memory request stable until accepted
//  - read byte one cycle after each accepted read
//  - one memory access in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module xm_tb_props
    import xm_pkg::*;
(
    input wire logic     clk,
    input wire logic     reset_i,
    input wire logic     bus_valid_i,
    input wire bus_txn_t bus_txn_i,
    input wire logic     bus_ready_i,
    input wire logic     bus_rvalid_i,
    input wire mem_req_t mem_req_i,
    input wire logic     mem_req_valid_i,
    input wire logic     mem_req_ready_i,
    input wire logic     mem_rsp_valid_i
);

int unsigned fail_count = 0;                    // read from the testbench top
logic        in_flight;                         // accepted, response still pending

always_ff @(posedge clk) begin
    if (reset_i) begin
        in_flight <= 1'b0;
    end else if (mem_req_valid_i && mem_req_ready_i) begin
        in_flight <= 1'b1;
    end else if (mem_rsp_valid_i) begin
        in_flight <= 1'b0;
    end
end

req_stable: assert property (@(posedge clk) disable iff (reset_i)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
    else begin
        $error("memory request dropped or changed before it was accepted");
        fail_count = fail_count + 1;
    end

read_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
    bus_rvalid_i == $past(bus_valid_i && bus_ready_i && bus_txn_i.rd_nwr))
    else begin
        $error("read byte valid does not follow an accepted read by one cycle");
        fail_count = fail_count + 1;
    end

busy_blocks_bus: assert property (@(posedge clk) disable iff (reset_i)
    mem_req_valid_i |-> !bus_ready_i)
    else begin
        $error("bus ready while a memory request is pending");
        fail_count = fail_count + 1;
    end

single_access: assert property (@(posedge clk) disable iff (reset_i)
    in_flight |-> !mem_req_valid_i)
    else begin
        $error("second memory request issued before the response");
        fail_count = fail_count + 1;
    end

endmodule

bind xm_top xm_tb_props u_props (
    .clk             (clk),
    .reset_i         (reset_i),
    .bus_valid_i     (bus_valid_i),
    .bus_txn_i       (bus_txn_i),
    .bus_ready_i     (bus_ready_o),
    .bus_rvalid_i    (bus_rvalid_o),
    .mem_req_i       (mem_req_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i)
);

`default_nettype wire

// ==== sim/xm_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of the host register block
//  - clock, reset and watchdog
//  - video memory and XR bus models, random stalls
//  - register reference model and readback checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module xm_tb
    import xm_pkg::*;
();

localparam int CLK_PERIOD      = 40;
localparam int NUM_TESTS       = 6;
localparam int CYCLES_PER_TEST = 400;
localparam int MEM_AW          = 6;             // 64-entry memory models

logic     clk;
logic     reset_i;
logic     bus_valid_i;
bus_txn_t bus_txn_i;
logic     bus_ready_o;
byte_t    bus_rdata_o;
logic     bus_rvalid_o;
mem_req_t mem_req_o;
logic     mem_req_valid_o;
logic     mem_req_ready_i;
mem_rsp_t mem_rsp_i;
logic     mem_rsp_valid_i;

word_t       vram [2**MEM_AW];
word_t       xram [2**MEM_AW];
word_t       exp_vram [2**MEM_AW];             // expected contents
word_t       exp_xram [2**MEM_AW];
xm_regs_t    model;                             // expected address registers
word_t       model_data;
word_t       model_xr_data;
logic [31:0] lfsr_q;
logic        stall_en;
int          errors;
int          err_mark;

xm_top dut (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout: tests did not finish in %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("Testbench failed");
    $finish;
end

function automatic logic lfsr_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (b ? 32'h8020_0003 : 32'h0);    // galois taps
    return b;
endfunction

function automatic int stall_cycles();
    int n;
    n = 0;
    if (stall_en) begin
        n = lfsr_bit();
        n = 2 * n + lfsr_bit();                 // 0..3 cycles
    end
    return n;
endfunction

function automatic int failures();
    return errors + dut.u_props.fail_count;
endfunction

task automatic step_cycle();
    @(posedge clk);
    #1;
endtask

initial begin : mem_model
    mem_req_t req;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    forever begin
        step_cycle();
        if (mem_req_valid_o) begin
            req = mem_req_o;
            repeat (stall_cycles()) step_cycle();
            mem_req_ready_i = 1'b1;
            step_cycle();                       // request taken on this edge
            mem_req_ready_i = 1'b0;
            if (req.wr && req.xr_sel) begin
                xram[req.addr[MEM_AW-1:0]] = req.data;
            end else if (req.wr) begin
                vram[req.addr[MEM_AW-1:0]] = req.data;
            end
            repeat (stall_cycles()) step_cycle();
            mem_rsp_i.data  = req.xr_sel ? xram[req.addr[MEM_AW-1:0]]
                                         : vram[req.addr[MEM_AW-1:0]];
            mem_rsp_valid_i = 1'b1;
            step_cycle();
            mem_rsp_valid_i = 1'b0;
        end
    end
end

task automatic model_prefetch();
    model_data    = exp_vram[model.rd_addr[MEM_AW-1:0]];
    model.rd_addr = model.rd_addr + model.rd_incr;
endtask

task automatic model_write(input logic [3:0] num, input word_t w);
    case (num)
        XM_XR_ADDR: begin
            model.xr_addr = w;
            model_xr_data = exp_xram[w[MEM_AW-1:0]];
        end
        XM_XR_DATA: begin
            exp_xram[model.xr_addr[MEM_AW-1:0]] = w;
            model.xr_addr = model.xr_addr + 16'd1;
        end
        XM_RD_INCR: model.rd_incr = w;
        XM_RD_ADDR: begin
            model.rd_addr = w;
            model_prefetch();
        end
        XM_WR_INCR: model.wr_incr = w;
        XM_WR_ADDR: model.wr_addr = w;
        XM_DATA, XM_DATA_2: begin
            exp_vram[model.wr_addr[MEM_AW-1:0]] = w;
            model.wr_addr = model.wr_addr + model.wr_incr;
        end
        default: ;
    endcase
endtask

function automatic word_t model_word(input logic [3:0] num);
    case (num)
        XM_XR_ADDR:         return model.xr_addr;
        XM_XR_DATA:         return model_xr_data;
        XM_RD_INCR:         return model.rd_incr;
        XM_RD_ADDR:         return model.rd_addr;
        XM_WR_INCR:         return model.wr_incr;
        XM_WR_ADDR:         return model.wr_addr;
        XM_DATA, XM_DATA_2: return model_data;
        default:            return '0;
    endcase
endfunction

task automatic check_word(input word_t got, input word_t exp, input string what);
    assert (got == exp) else begin
        $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

// waits for ready, returns the read byte of the cycle after acceptance
task automatic bus_xfer(input logic rd, input logic [3:0] num, input logic sel,
                        input byte_t wdata, output byte_t rdata);
    bus_txn_i   = {rd, num, sel, wdata};
    bus_valid_i = 1'b1;
    while (!bus_ready_o) begin
        step_cycle();
    end
    step_cycle();                               // accepted on this edge
    bus_valid_i = 1'b0;
    rdata       = bus_rdata_o;
endtask

task automatic write_word(input logic [3:0] num, input word_t w);
    byte_t unused;
    bus_xfer(1'b0, num, 1'b0, w[15:8], unused);
    bus_xfer(1'b0, num, 1'b1, w[7:0], unused);
    model_write(num, w);
endtask

task automatic read_check(input logic [3:0] num);
    word_t exp;
    byte_t hi;
    byte_t lo;
    exp = model_word(num);
    bus_xfer(1'b1, num, 1'b0, 8'h00, hi);
    bus_xfer(1'b1, num, 1'b1, 8'h00, lo);       // odd byte last
    check_word({hi, lo}, exp, $sformatf("register %0d", num));
    if (num == XM_DATA || num == XM_DATA_2) begin
        model_prefetch();
    end
endtask

task automatic check_mem();
    int i;
    for (i = 0; i < 2**MEM_AW; i++) begin
        check_word(vram[i], exp_vram[i], $sformatf("video memory word %0d", i));
        check_word(xram[i], exp_xram[i], $sformatf("XR bus word %0d", i));
    end
endtask

task automatic write_seq(input word_t addr, input word_t incr, input word_t first,
                         input int count);
    int i;
    write_word(XM_WR_INCR, incr);
    write_word(XM_WR_ADDR, addr);
    for (i = 0; i < count; i++) begin
        write_word(i[0] ? XM_DATA_2 : XM_DATA, first + word_t'(i) * 16'h1111);
    end
    read_check(XM_WR_ADDR);
    check_mem();
endtask

task automatic read_seq(input word_t addr, input word_t incr, input int count);
    int i;
    write_word(XM_RD_INCR, incr);
    write_word(XM_RD_ADDR, addr);
    for (i = 0; i < count; i++) begin
        read_check(i[0] ? XM_DATA_2 : XM_DATA);
    end
    read_check(XM_RD_ADDR);
endtask

task automatic xr_seq(input word_t addr, input word_t w);
    write_word(XM_XR_ADDR, addr);
    read_check(XM_XR_DATA);
    write_word(XM_XR_DATA, w);
    write_word(XM_XR_DATA, ~w);
    read_check(XM_XR_ADDR);                     // two above the start
    write_word(XM_XR_ADDR, addr);
    read_check(XM_XR_DATA);
    check_mem();
endtask

task automatic end_test(input int num, input string name);
    $display("test %0d done: %s, %0d failures", num, name, failures() - err_mark);
    err_mark = failures();
endtask

initial begin : main
    int n;
    reset_i       = 1'b1;
    bus_valid_i   = 1'b0;
    bus_txn_i     = '0;
    stall_en      = 1'b0;
    lfsr_q        = 32'h7236;
    errors        = 0;
    err_mark      = 0;
    model         = '0;
    model_data    = '0;
    model_xr_data = '0;
    for (n = 0; n < 2**MEM_AW; n++) begin
        vram[n]     = 16'h1000 + 16'h0103 * word_t'(n);
        xram[n]     = 16'hC000 + 16'h0205 * word_t'(n);
        exp_vram[n] = vram[n];
        exp_xram[n] = xram[n];
    end
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;

    for (n = 0; n < 16; n++) begin
        read_check(n[3:0]);
    end
    for (n = 8; n < 16; n++) begin
        write_word(n[3:0], 16'hA5A5 ^ word_t'(n));
        read_check(n[3:0]);                     // unused numbers stay zero
    end
    end_test(1, "reset values and unused registers");

    write_word(XM_RD_INCR, 16'h0102);
    write_word(XM_WR_INCR, 16'h0304);
    write_word(XM_WR_ADDR, 16'h1234);
    write_word(XM_RD_ADDR, 16'h0040);
    write_word(XM_XR_ADDR, 16'h0021);
    for (n = 0; n < 6; n++) begin
        read_check(n[3:0]);
    end
    end_test(2, "address and increment readback");

    write_seq(16'h0008, 16'h0003, 16'h2468, 5);
    end_test(3, "video memory writes");
    read_seq(16'h0008, 16'h0003, 5);
    end_test(4, "video memory reads with prefetch");
    xr_seq(16'h0005, 16'hBEEF);
    end_test(5, "extended register bus");

    stall_en = 1'b1;
    write_seq(16'h0030, 16'hFFFF, 16'h5A5A, 6);   // descending addresses
    read_seq(16'h0030, 16'hFFFF, 6);
    xr_seq(16'h003F, 16'hC3C3);
    end_test(6, "random memory stalls");

    $display("%0d tests run, %0d checks failed, %0d assertions failed",
             NUM_TESTS, errors, dut.u_props.fail_count);
    if (failures() == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
src/xm_pkg.sv
src/xm_bus_decode.sv
src/xm_reg_execute.sv
src/xm_read_result.sv
src/xm_top.sv
sim/xm_tb_props.sv
sim/xm_tb.sv

// ==== Bender.yml ====
package:
  name: xm_host_regs

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/xm_pkg.sv
      - src/xm_bus_decode.sv
      - src/xm_reg_execute.sv
      - src/xm_read_result.sv
      - src/xm_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/xm_tb_props.sv
      - sim/xm_tb.sv
